// File: core_pkg.sv
/* Core-wide widths, register and data types, execution commands
   and the load/store result record */

`default_nettype none

package core_pkg;

    // Data path and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Commands handed out by the issuer
    typedef enum logic [4:0] {
        c_NONE,
        // Arithmetic, owned by the other units
        c_ADD,
        c_SUB,
        c_AND,
        c_OR,
        // Loads
        c_LB,
        c_LH,
        c_LW,
        c_LBU,
        c_LHU,
        // Stores
        c_SB,
        c_SH,
        c_SW
    } exec_cmd_t;

    // Result held for the committer
    typedef struct packed {
        xlen_t     data;
        reg_addr_t rd;
        logic      err;
    } lsu_result_t;

endpackage

`default_nettype wire

// File: data_ram.sv
/* Word-addressed byte-enabled synchronous data RAM with range error */

`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int RAM_DEPTH_WORDS = 256
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    i_req,
    input  wire mem_pkg::mem_req_t i_mem,
    output mem_pkg::mem_rsp_t      o_mem
);

    localparam int IDX_W = $clog2(RAM_DEPTH_WORDS);

    core_pkg::xlen_t           mem [RAM_DEPTH_WORDS];
    logic [core_pkg::XLEN-3:0] word_idx;
    logic [IDX_W-1:0]          ram_idx;
    logic                      in_range;

    assign word_idx = i_mem.addr[core_pkg::XLEN-1:2];
    assign ram_idx  = word_idx[IDX_W-1:0];
    assign in_range = (word_idx < RAM_DEPTH_WORDS);

    // Lane-masked write, out-of-range requests are dropped
    always_ff @(posedge clk) begin
        if (i_req && i_mem.we && in_range) begin
            for (int b = 0; b < mem_pkg::LANES; b++) begin
                if (i_mem.byteen[b]) begin
                    mem[ram_idx][8*b +: 8] <= i_mem.wdata[8*b +: 8];
                end
            end
        end
    end

    // One-cycle read with error flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_mem <= '0;
        end else if (i_req) begin
            if (in_range) begin
                o_mem.rdata <= mem[ram_idx];
                o_mem.err   <= 1'b0;
            end else begin
                o_mem.rdata <= '0;
                o_mem.err   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: files.f
core_pkg.sv
mem_pkg.sv
lsu_store_align.sv
lsu_load_extract.sv
lsu.sv
data_ram.sv
lsu_top.sv
tb_lsu_top.sv

// File: lsu.sv
/* Load/store unit FSM: command capture, two-cycle memory request,
   response capture and held result */

`timescale 1ns/1ns
`default_nettype none

module lsu (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire core_pkg::exec_cmd_t  i_cmd,
    input  wire core_pkg::xlen_t      i_base,
    input  wire core_pkg::xlen_t      i_imm,
    input  wire core_pkg::xlen_t      i_store_data,
    input  wire core_pkg::reg_addr_t  i_rd,
    output logic                      o_busy,
    output logic                      o_illegal,
    output logic                      o_valid,
    output core_pkg::lsu_result_t     o_result,
    input  wire                       i_clear,
    output logic                      o_mem_req,
    output mem_pkg::mem_req_t         o_mem,
    input  wire mem_pkg::mem_rsp_t    i_mem
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        OUT
    } lsu_state_t;

    lsu_state_t          state;
    lsu_state_t          next_state;

    core_pkg::xlen_t     a_word_addr;
    mem_pkg::byteen_t    a_byteen;
    core_pkg::xlen_t     a_wdata;
    logic                a_we;
    logic                a_is_load;
    logic                a_sign_ext;
    logic                a_illegal;
    logic                accept;

    mem_pkg::mem_req_t   r_req;
    core_pkg::reg_addr_t r_rd;
    logic                r_is_load;
    logic                r_sign_ext;
    core_pkg::xlen_t     r_rdata;
    logic                r_err;
    core_pkg::xlen_t     ld_data;

    // Offset is already folded into the byte enables
    lsu_store_align u_align (
        .i_cmd        (i_cmd),
        .i_base       (i_base),
        .i_imm        (i_imm),
        .i_store_data (i_store_data),
        .o_word_addr  (a_word_addr),
        .o_offset     (),
        .o_byteen     (a_byteen),
        .o_wdata      (a_wdata),
        .o_we         (a_we),
        .o_is_load    (a_is_load),
        .o_sign_ext   (a_sign_ext),
        .o_illegal    (a_illegal)
    );

    lsu_load_extract u_extract (
        .i_word     (r_rdata),
        .i_byteen   (r_req.byteen),
        .i_sign_ext (r_sign_ext),
        .o_data     (ld_data)
    );

    assign accept    = (state == IDLE) && (a_is_load || a_we);
    assign o_illegal = (state == IDLE) && a_illegal;

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: if (accept) next_state = REQ;
            REQ:  next_state = WAIT;
            WAIT: next_state = OUT;
            OUT:  if (i_clear) next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            r_req      <= '0;
            r_rd       <= '0;
            r_is_load  <= 1'b0;
            r_sign_ext <= 1'b0;
            r_rdata    <= '0;
            r_err      <= 1'b0;
        end else begin
            state <= next_state;
            if (accept) begin
                r_req.addr   <= a_word_addr;
                r_req.byteen <= a_byteen;
                r_req.we     <= a_we;
                r_req.wdata  <= a_wdata;
                r_rd         <= i_rd;
                r_is_load    <= a_is_load;
                r_sign_ext   <= a_sign_ext;
            end
            // Response registered by the RAM at the end of REQ
            if (state == WAIT) begin
                r_rdata <= r_is_load ? i_mem.rdata : '0;
                r_err   <= i_mem.err;
            end
        end
    end

    assign o_busy    = (state != IDLE);
    assign o_valid   = (state == OUT);
    assign o_mem_req = (state == REQ) || (state == WAIT);
    assign o_mem     = r_req;

    always_comb begin
        o_result.data = ld_data;
        o_result.rd   = r_rd;
        o_result.err  = r_err;
    end

endmodule

`default_nettype wire

// File: lsu_load_extract.sv
/* Byte and half selection from a returned word with sign or zero extension */

`timescale 1ns/1ns
`default_nettype none

module lsu_load_extract (
    input  wire core_pkg::xlen_t  i_word,
    input  wire mem_pkg::byteen_t i_byteen,
    input  wire                   i_sign_ext,
    output core_pkg::xlen_t       o_data
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic        byte_fill;
    logic        half_fill;

    // Lowest enabled byte lane
    always_comb begin
        casez (i_byteen)
            4'b???1: byte_val = i_word[7:0];
            4'b??10: byte_val = i_word[15:8];
            4'b?100: byte_val = i_word[23:16];
            default: byte_val = i_word[31:24];
        endcase
    end

    assign half_val  = i_byteen[0] ? i_word[15:0] : i_word[31:16];
    assign byte_fill = i_sign_ext & byte_val[7];
    assign half_fill = i_sign_ext & half_val[15];

    always_comb begin
        case (i_byteen)
            4'b1111: begin
                o_data = i_word;
            end
            4'b0011, 4'b1100: begin
                o_data = {{(core_pkg::XLEN-16){half_fill}}, half_val};
            end
            4'b0000: begin
                // Nothing enabled, only before the first command
                o_data = '0;
            end
            default: begin
                o_data = {{(core_pkg::XLEN-8){byte_fill}}, byte_val};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: lsu_store_align.sv
/* Effective address, byte enables and lane placement of store data
   for one load/store command */

`timescale 1ns/1ns
`default_nettype none

module lsu_store_align (
    input  wire core_pkg::exec_cmd_t i_cmd,
    input  wire core_pkg::xlen_t     i_base,
    input  wire core_pkg::xlen_t     i_imm,
    input  wire core_pkg::xlen_t     i_store_data,
    output core_pkg::xlen_t          o_word_addr,
    output logic [1:0]               o_offset,
    output mem_pkg::byteen_t         o_byteen,
    output core_pkg::xlen_t          o_wdata,
    output logic                     o_we,
    output logic                     o_is_load,
    output logic                     o_sign_ext,
    output logic                     o_illegal
);

    core_pkg::xlen_t ea;
    logic            is_byte;
    logic            is_half;
    logic            is_word;

    assign ea          = i_base + i_imm;
    assign o_word_addr = {ea[core_pkg::XLEN-1:2], 2'b00};
    assign o_offset    = ea[1:0];

    // Decode access size and direction
    always_comb begin
        is_byte    = 1'b0;
        is_half    = 1'b0;
        is_word    = 1'b0;
        o_is_load  = 1'b0;
        o_we       = 1'b0;
        o_sign_ext = 1'b0;
        o_illegal  = 1'b0;
        unique case (i_cmd)
            core_pkg::c_LB: begin
                is_byte    = 1'b1;
                o_is_load  = 1'b1;
                o_sign_ext = 1'b1;
            end
            core_pkg::c_LH: begin
                is_half    = 1'b1;
                o_is_load  = 1'b1;
                o_sign_ext = 1'b1;
            end
            core_pkg::c_LW: begin
                is_word    = 1'b1;
                o_is_load  = 1'b1;
                o_sign_ext = 1'b1;
            end
            core_pkg::c_LBU: begin
                is_byte   = 1'b1;
                o_is_load = 1'b1;
            end
            core_pkg::c_LHU: begin
                is_half   = 1'b1;
                o_is_load = 1'b1;
            end
            core_pkg::c_SB: begin
                is_byte = 1'b1;
                o_we    = 1'b1;
            end
            core_pkg::c_SH: begin
                is_half = 1'b1;
                o_we    = 1'b1;
            end
            core_pkg::c_SW: begin
                is_word = 1'b1;
                o_we    = 1'b1;
            end
            core_pkg::c_NONE: begin
                is_byte = 1'b0;
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

    // Lane enables, a half only looks at offset bit 1
    always_comb begin
        if (is_word) begin
            o_byteen = 4'b1111;
        end else if (is_half) begin
            o_byteen = o_offset[1] ? 4'b1100 : 4'b0011;
        end else if (is_byte) begin
            o_byteen = 4'b0001 << o_offset;
        end else begin
            o_byteen = 4'b0000;
        end
    end

    // Move store data onto the enabled lanes
    always_comb begin
        if (!o_we) begin
            o_wdata = '0;
        end else if (is_word) begin
            o_wdata = i_store_data;
        end else if (is_half) begin
            o_wdata = o_offset[1] ? {i_store_data[15:0], 16'h0000}
                                  : {16'h0000, i_store_data[15:0]};
        end else begin
            o_wdata = {{(core_pkg::XLEN-8){1'b0}}, i_store_data[7:0]} << {o_offset, 3'b000};
        end
    end

endmodule

`default_nettype wire

// File: lsu_top.sv
/* Memory stage subsystem: load/store unit with its data RAM */

`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
    parameter int RAM_DEPTH_WORDS = 256
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire core_pkg::exec_cmd_t i_cmd,
    input  wire core_pkg::xlen_t     i_base,
    input  wire core_pkg::xlen_t     i_imm,
    input  wire core_pkg::xlen_t     i_store_data,
    input  wire core_pkg::reg_addr_t i_rd,
    input  wire                      i_clear,
    output logic                     o_busy,
    output logic                     o_illegal,
    output logic                     o_valid,
    output core_pkg::lsu_result_t    o_result
);

    logic              mem_req;
    mem_pkg::mem_req_t mem_bus;
    mem_pkg::mem_rsp_t mem_rsp;

    lsu u_lsu (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cmd        (i_cmd),
        .i_base       (i_base),
        .i_imm        (i_imm),
        .i_store_data (i_store_data),
        .i_rd         (i_rd),
        .o_busy       (o_busy),
        .o_illegal    (o_illegal),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .i_clear      (i_clear),
        .o_mem_req    (mem_req),
        .o_mem        (mem_bus),
        .i_mem        (mem_rsp)
    );

    data_ram #(
        .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
    ) u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .i_req (mem_req),
        .i_mem (mem_bus),
        .o_mem (mem_rsp)
    );

endmodule

`default_nettype wire

// File: mem_pkg.sv
/* Data memory request and response records and the byte-lane enable type */

`default_nettype none

package mem_pkg;

    // One enable bit per byte of a word
    localparam int LANES = core_pkg::XLEN / 8;

    typedef logic [LANES-1:0] byteen_t;

    // Request from the load/store unit, addr is word aligned
    typedef struct packed {
        core_pkg::xlen_t addr;
        byteen_t         byteen;
        logic            we;
        core_pkg::xlen_t wdata;
    } mem_req_t;

    // Registered RAM response
    typedef struct packed {
        core_pkg::xlen_t rdata;
        logic            err;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal --top-module tb_lsu_top -f files.f -o sim_lsu_top \
    && out=$(./obj_dir/sim_lsu_top) \
    && echo "$out" \
    && echo "$out" | grep -qx "Test OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tb_lsu_top.sv
/* Random self-checking testbench for the memory stage subsystem
   with a shadow byte memory and a load extension model */

`timescale 1ns/1ns
`default_nettype none

module tb_lsu_top;

    localparam int DEPTH = 256;
    localparam int BYTES = DEPTH * 4;

    logic                  clk;
    logic                  rst_n;
    core_pkg::exec_cmd_t   i_cmd;
    core_pkg::xlen_t       i_base;
    core_pkg::xlen_t       i_imm;
    core_pkg::xlen_t       i_store_data;
    core_pkg::reg_addr_t   i_rd;
    logic                  i_clear;
    logic                  o_busy;
    logic                  o_illegal;
    logic                  o_valid;
    core_pkg::lsu_result_t o_result;

    logic [7:0]            shadow [BYTES];
    integer                seed = 67;
    int                    checks = 0;
    int                    errors = 0;
    int                    mark_checks = 0;
    int                    mark_errors = 0;

    core_pkg::exec_cmd_t   mem_cmds [8] = '{core_pkg::c_LB, core_pkg::c_LH, core_pkg::c_LW,
                                            core_pkg::c_LBU, core_pkg::c_LHU, core_pkg::c_SB,
                                            core_pkg::c_SH, core_pkg::c_SW};

    lsu_top #(
        .RAM_DEPTH_WORDS (DEPTH)
    ) lsu_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cmd        (i_cmd),
        .i_base       (i_base),
        .i_imm        (i_imm),
        .i_store_data (i_store_data),
        .i_rd         (i_rd),
        .i_clear      (i_clear),
        .o_busy       (o_busy),
        .o_illegal    (o_illegal),
        .o_valid      (o_valid),
        .o_result     (o_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_result(input string name, input core_pkg::lsu_result_t got,
                                input core_pkg::lsu_result_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got data=%h rd=%0d err=%b, expected data=%h rd=%0d err=%b",
                     $time, name, got.data, got.rd, got.err,
                     expected.data, expected.rd, expected.err);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    function automatic logic in_range(input core_pkg::xlen_t ea);
        return (ea >> 2) < core_pkg::xlen_t'(DEPTH);
    endfunction

    function automatic logic is_load(input core_pkg::exec_cmd_t cmd);
        return cmd inside {core_pkg::c_LB, core_pkg::c_LH, core_pkg::c_LW,
                           core_pkg::c_LBU, core_pkg::c_LHU};
    endfunction

    // Half accesses use only address bit 1, words ignore both low bits
    task automatic model_store(input core_pkg::exec_cmd_t cmd, input core_pkg::xlen_t ea,
                               input core_pkg::xlen_t sdata);
        int a;
        int w;
        if (!in_range(ea)) return;
        a = int'(ea);
        w = a - (a % 4);
        case (cmd)
            core_pkg::c_SB: shadow[a] = sdata[7:0];
            core_pkg::c_SH: begin
                shadow[w + (a & 2)]     = sdata[7:0];
                shadow[w + (a & 2) + 1] = sdata[15:8];
            end
            core_pkg::c_SW: begin
                for (int i = 0; i < 4; i++) begin
                    shadow[w + i] = sdata[8*i +: 8];
                end
            end
            default: ;
        endcase
    endtask

    function automatic core_pkg::xlen_t model_load(input core_pkg::exec_cmd_t cmd,
                                                   input core_pkg::xlen_t ea);
        int              a;
        int              w;
        logic [7:0]      b;
        logic [15:0]     h;
        core_pkg::xlen_t r;
        if (!in_range(ea)) return '0;
        a = int'(ea);
        w = a - (a % 4);
        b = shadow[a];
        h = {shadow[w + (a & 2) + 1], shadow[w + (a & 2)]};
        case (cmd)
            core_pkg::c_LB:  r = {{24{b[7]}}, b};
            core_pkg::c_LBU: r = {24'h000000, b};
            core_pkg::c_LH:  r = {{16{h[15]}}, h};
            core_pkg::c_LHU: r = {16'h0000, h};
            core_pkg::c_LW:  r = {shadow[w + 3], shadow[w + 2], shadow[w + 1], shadow[w]};
            default:         r = '0;
        endcase
        return r;
    endfunction

    // One command from issue to clear, with latency and hold checks
    task automatic run_access(input core_pkg::exec_cmd_t cmd, input core_pkg::xlen_t ea,
                              input core_pkg::xlen_t sdata, input int hold,
                              output core_pkg::lsu_result_t res);
        core_pkg::xlen_t       imm;
        core_pkg::reg_addr_t   rd;
        core_pkg::lsu_result_t expected;
        int                    cycles;
        imm           = core_pkg::xlen_t'($random(seed) % 256);
        rd            = core_pkg::reg_addr_t'($random(seed));
        expected.rd   = rd;
        expected.err  = !in_range(ea);
        expected.data = is_load(cmd) ? model_load(cmd, ea) : '0;
        if (!is_load(cmd)) model_store(cmd, ea, sdata);
        @(negedge clk);
        i_cmd        = cmd;
        i_base       = ea - imm;
        i_imm        = imm;
        i_store_data = sdata;
        i_rd         = rd;
        @(negedge clk);
        check_bit("o_busy", o_busy, 1'b1);
        i_cmd  = core_pkg::c_NONE;
        cycles = 1;
        while (!o_valid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        res = o_result;
        if (!o_valid) begin
            errors++;
            $display("o_valid did not rise within 20 cycles of a %s command", cmd.name());
        end else begin
            check_count("o_valid latency", cycles, 3);
            check_result("o_result", o_result, expected);
            repeat (hold) begin
                @(negedge clk);
                check_bit("o_valid", o_valid, 1'b1);
                check_result("o_result held", o_result, expected);
            end
            i_clear = 1'b1;
            @(negedge clk);
            i_clear = 1'b0;
            check_bit("o_busy", o_busy, 1'b0);
            check_bit("o_valid", o_valid, 1'b0);
        end
    endtask

    // A command shown for one edge while idle
    task automatic present_idle(input core_pkg::exec_cmd_t cmd, input logic exp_illegal);
        @(negedge clk);
        i_cmd  = cmd;
        i_base = $random(seed);
        i_imm  = $random(seed);
        @(negedge clk);
        check_bit("o_illegal", o_illegal, exp_illegal);
        check_bit("o_busy", o_busy, 1'b0);
        i_cmd = core_pkg::c_NONE;
        @(negedge clk);
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_illegal", o_illegal, 1'b0);
    endtask

    initial begin
        core_pkg::lsu_result_t res;
        core_pkg::xlen_t       ea;
        core_pkg::xlen_t       sdata;
        int                    idx;
        rst_n        = 1'b0;
        i_cmd        = core_pkg::c_NONE;
        i_base       = '0;
        i_imm        = '0;
        i_store_data = '0;
        i_rd         = '0;
        i_clear      = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_bit("o_valid", o_valid, 1'b0);
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_illegal", o_illegal, 1'b0);
        check_result("o_result", o_result, '0);
        report_test("reset state");

        // Known contents everywhere before mixed traffic
        for (int w = 0; w < DEPTH; w++) begin
            run_access(core_pkg::c_SW, core_pkg::xlen_t'(w * 4), $random(seed), 0, res);
        end
        repeat (300) begin
            idx = $unsigned($random(seed)) % 8;
            ea  = core_pkg::xlen_t'($random(seed)) & 32'h0000_03ff;
            run_access(mem_cmds[idx], ea, $random(seed), $unsigned($random(seed)) % 4, res);
        end
        report_test("random stores and loads");

        repeat (8) begin
            ea    = core_pkg::xlen_t'($random(seed)) & 32'h0000_03ff;
            sdata = core_pkg::xlen_t'($random(seed)) | 32'h0000_8080;
            run_access(core_pkg::c_SB, ea, sdata, 0, res);
            run_access(core_pkg::c_LB, ea, '0, 0, res);
            check_bit("LB o_result.data[31]", res.data[31], 1'b1);
            run_access(core_pkg::c_LBU, ea, '0, 0, res);
            check_bit("LBU o_result.data[31]", res.data[31], 1'b0);
            run_access(core_pkg::c_SH, ea, sdata, 0, res);
            run_access(core_pkg::c_LH, ea, '0, 0, res);
            check_bit("LH o_result.data[31]", res.data[31], 1'b1);
            run_access(core_pkg::c_LHU, ea, '0, 0, res);
            check_bit("LHU o_result.data[31]", res.data[31], 1'b0);
        end
        report_test("sign extension");

        repeat (20) begin
            ea = $random(seed);
            if (in_range(ea)) ea[20] = 1'b1;
            idx = $unsigned($random(seed)) % 8;
            run_access(mem_cmds[idx], ea, $random(seed), 0, res);
            // Same RAM index as the rejected access
            run_access(core_pkg::c_LW, ea & 32'h0000_03ff, '0, 0, res);
        end
        report_test("out of range access");

        present_idle(core_pkg::c_ADD, 1'b1);
        present_idle(core_pkg::c_SUB, 1'b1);
        present_idle(core_pkg::c_AND, 1'b1);
        present_idle(core_pkg::c_OR, 1'b1);
        present_idle(core_pkg::c_NONE, 1'b0);
        run_access(core_pkg::c_LW, 32'h0000_0010, '0, 0, res);
        report_test("illegal commands");

        repeat (10) begin
            idx = $unsigned($random(seed)) % 8;
            ea  = core_pkg::xlen_t'($random(seed)) & 32'h0000_03ff;
            run_access(mem_cmds[idx], ea, $random(seed), 2 + $unsigned($random(seed)) % 16, res);
        end
        report_test("latency and hold");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
